/* rv_core_pkg.sv */
`default_nettype none

package rv_core_pkg;

  localparam int xlen = 32;
  localparam int nreg = 16;

  typedef logic [$clog2(nreg)-1:0] reg_idx_t;

  // Machine CSR addresses that this core implements
  typedef enum logic [11:0] {
    csr_mstatus   = 12'h300,
    csr_mtvec     = 12'h305,
    csr_mepc      = 12'h341,
    csr_mcause    = 12'h342,
    csr_mvendorid = 12'hF11,
    csr_marchid   = 12'hF12
  } csr_addr_e;

  typedef enum logic [1:0] {
    csr_none,
    csr_write,
    csr_ecall,
    csr_mret
  } csr_op_e;

  localparam logic [xlen-1:0] mstatus_reset   = 32'h0000_1800;
  localparam logic [xlen-1:0] mstatus_ecall   = 32'h0000_1800;
  localparam logic [xlen-1:0] mcause_ecall    = 32'h0000_000b;
  localparam logic [xlen-1:0] mvendorid_value = 32'h7973_7978;
  localparam logic [xlen-1:0] marchid_value   = 32'h017D_C685;

  // Bit positions inside mstatus touched by mret
  localparam int mstatus_mie    = 3;
  localparam int mstatus_mpie   = 7;
  localparam int mstatus_mpp_lo = 11;
  localparam int mstatus_mpp_hi = 12;

  typedef struct packed {
    reg_idx_t  rs1;
    reg_idx_t  rs2;
    csr_addr_e csr_addr;
    logic      inst_ecall;
    logic      inst_mret;
  } rd_req_t;

  typedef struct packed {
    logic [xlen-1:0] src1;
    logic [xlen-1:0] src2;
    logic [xlen-1:0] csr_data;
  } rd_rsp_t;

  typedef struct packed {
    logic [xlen-1:0] pc;
    reg_idx_t        rd;
    logic            gpr_wen;
    logic [xlen-1:0] gpr_wdata;
    csr_op_e         csr_op;
    csr_addr_e       csr_addr;
    logic [xlen-1:0] csr_wdata;
  } exu_to_wb_t;

  // The en flag is high only in the cycle the write is applied
  typedef struct packed {
    logic            en;
    logic            gpr_we;
    reg_idx_t        rd;
    logic [xlen-1:0] gpr_wdata;
    csr_op_e         csr_op;
    csr_addr_e       csr_addr;
    logic [xlen-1:0] csr_wdata;
    logic [xlen-1:0] pc;
  } commit_t;

  typedef struct packed {
    logic [xlen-1:0] mtvec;
    logic [xlen-1:0] mepc;
  } trap_vec_t;

endpackage

`default_nettype wire

/* gpr_file.sv */
`timescale 1ns/1ps
`default_nettype none

module gpr_file
  import rv_core_pkg::*;
(
  input  wire logic            clk,
  input  wire logic            rst_n,
  input  wire commit_t         commit,
  input  wire reg_idx_t        rs1,
  input  wire reg_idx_t        rs2,
  output logic      [xlen-1:0] src1,
  output logic      [xlen-1:0] src2
);

  logic [xlen-1:0] regs [nreg];

  // Entry 0 is never written, so it keeps its reset value of zero
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < nreg; i++) begin
        regs[i] <= '0;
      end
    end else if (commit.en && commit.gpr_we && (commit.rd != '0)) begin
      regs[commit.rd] <= commit.gpr_wdata;
    end
  end

  assign src1 = regs[rs1];
  assign src2 = regs[rs2];

  x0_stays_zero: assert property (
    @(posedge clk) disable iff (!rst_n) regs[0] == '0
  ) else $error("x0 holds a nonzero value");

endmodule

`default_nettype wire

/* csr_file.sv */
`timescale 1ns/1ps
`default_nettype none

module csr_file
  import rv_core_pkg::*;
(
  input  wire logic             clk,
  input  wire logic             rst_n,
  input  wire commit_t          commit,
  input  wire csr_addr_e        csr_addr,
  input  wire logic             inst_ecall,
  input  wire logic             inst_mret,
  output logic       [xlen-1:0] csr_data,
  output trap_vec_t             trap_vec
);

  logic [xlen-1:0] mtvec;
  logic [xlen-1:0] mepc;
  logic [xlen-1:0] mstatus;
  logic [xlen-1:0] mcause;
  logic [xlen-1:0] mstatus_mret;

  // mret restores MIE from MPIE, sets MPIE and drops back to U mode
  always_comb begin
    mstatus_mret = mstatus;
    mstatus_mret[mstatus_mie] = mstatus[mstatus_mpie];
    mstatus_mret[mstatus_mpie] = 1'b1;
    mstatus_mret[mstatus_mpp_hi:mstatus_mpp_lo] = '0;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mtvec   <= '0;
      mepc    <= '0;
      mstatus <= mstatus_reset;
      mcause  <= '0;
    end else if (commit.en) begin
      case (commit.csr_op)
        csr_write: begin
          // Read-only and unknown addresses fall through untouched
          case (commit.csr_addr)
            csr_mtvec:   mtvec   <= commit.csr_wdata;
            csr_mepc:    mepc    <= commit.csr_wdata;
            csr_mstatus: mstatus <= commit.csr_wdata;
            csr_mcause:  mcause  <= commit.csr_wdata;
            default: ;
          endcase
        end
        csr_ecall: begin
          mepc    <= commit.pc;
          mcause  <= mcause_ecall;
          mstatus <= mstatus_ecall;
        end
        csr_mret: begin
          mstatus <= mstatus_mret;
        end
        default: ;
      endcase
    end
  end

  always_comb begin
    if (inst_ecall) begin
      csr_data = mtvec;
    end else if (inst_mret) begin
      csr_data = mepc;
    end else begin
      case (csr_addr)
        csr_mtvec:     csr_data = mtvec;
        csr_mepc:      csr_data = mepc;
        csr_mstatus:   csr_data = mstatus;
        csr_mcause:    csr_data = mcause;
        csr_mvendorid: csr_data = mvendorid_value;
        csr_marchid:   csr_data = marchid_value;
        default:       csr_data = '0;
      endcase
    end
  end

  assign trap_vec = '{mtvec: mtvec, mepc: mepc};

  // Decode flags a single system instruction at a time
  ecall_mret_exclusive: assert property (
    @(posedge clk) disable iff (!rst_n) !(inst_ecall && inst_mret)
  ) else $error("inst_ecall and inst_mret both set");

endmodule

`default_nettype wire

/* wb_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module wb_stage
  import rv_core_pkg::*;
(
  input  wire logic              clk,
  input  wire logic              rst_n,
  input  wire logic              exu_valid,
  input  wire exu_to_wb_t        exu_data,
  output logic                   exu_ready,
  input  wire trap_vec_t         trap_vec,
  output logic                   if_valid,
  output logic       [xlen-1:0]  if_next_pc,
  input  wire logic              if_ready,
  output commit_t                commit
);

  exu_to_wb_t entry;
  logic       exu_fire;
  logic       if_fire;

  assign exu_fire = exu_valid && exu_ready;
  assign if_fire  = if_valid && if_ready;

  // Take a new result while empty or while the held one leaves
  assign exu_ready = !if_valid || if_ready;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      if_valid <= 1'b0;
    end else if (exu_fire) begin
      if_valid <= 1'b1;
    end else if (if_fire) begin
      if_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (exu_fire) begin
      entry <= exu_data;
    end
  end

  // trap_vec cannot move before this entry commits, so the pre-commit
  // mtvec and mepc are what fetch sees
  always_comb begin
    case (entry.csr_op)
      csr_ecall: if_next_pc = trap_vec.mtvec;
      csr_mret:  if_next_pc = trap_vec.mepc;
      default:   if_next_pc = entry.pc + 32'd4;
    endcase
  end

  assign commit = '{
    en:        if_fire,
    gpr_we:    entry.gpr_wen,
    rd:        entry.rd,
    gpr_wdata: entry.gpr_wdata,
    csr_op:    entry.csr_op,
    csr_addr:  entry.csr_addr,
    csr_wdata: entry.csr_wdata,
    pc:        entry.pc
  };

  if_hold_on_stall: assert property (
    @(posedge clk) disable iff (!rst_n)
    (if_valid && !if_ready) |=> if_valid && $stable(if_next_pc)
  ) else $error("if_valid or if_next_pc moved while fetch stalled");

  if_idle_after_reset: assert property (
    @(posedge clk) $rose(rst_n) |-> !if_valid
  ) else $error("if_valid high coming out of reset");

endmodule

`default_nettype wire

/* reg_csr_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module reg_csr_unit
  import rv_core_pkg::*;
(
  input  wire logic             clk,
  input  wire logic             rst_n,
  input  wire rd_req_t          rd_req,
  output rd_rsp_t               rd_rsp,
  input  wire logic             exu_valid,
  input  wire exu_to_wb_t       exu_data,
  output logic                  exu_ready,
  output logic                  if_valid,
  output logic       [xlen-1:0] if_next_pc,
  input  wire logic             if_ready
);

  commit_t         commit;
  trap_vec_t       trap_vec;
  logic [xlen-1:0] src1;
  logic [xlen-1:0] src2;
  logic [xlen-1:0] csr_data;

  wb_stage wb_stage_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .exu_valid  (exu_valid),
    .exu_data   (exu_data),
    .exu_ready  (exu_ready),
    .trap_vec   (trap_vec),
    .if_valid   (if_valid),
    .if_next_pc (if_next_pc),
    .if_ready   (if_ready),
    .commit     (commit)
  );

  gpr_file gpr_file_i (
    .clk    (clk),
    .rst_n  (rst_n),
    .commit (commit),
    .rs1    (rd_req.rs1),
    .rs2    (rd_req.rs2),
    .src1   (src1),
    .src2   (src2)
  );

  csr_file csr_file_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .commit     (commit),
    .csr_addr   (rd_req.csr_addr),
    .inst_ecall (rd_req.inst_ecall),
    .inst_mret  (rd_req.inst_mret),
    .csr_data   (csr_data),
    .trap_vec   (trap_vec)
  );

  assign rd_rsp = '{src1: src1, src2: src2, csr_data: csr_data};

endmodule

`default_nettype wire

/* tb_reg_csr_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_reg_csr_unit
  import rv_core_pkg::*;
();

  localparam int clk_period = 100;
  localparam int settle = clk_period / 4;
  // Cycles for reset, gpr, csr, ecall, mret and back-pressure tests
  localparam int budget_cycles = 10 + 110 + 50 + 25 + 30 + 25;
  localparam csr_addr_e csr_unknown = csr_addr_e'(12'h7C0);

  logic            clk;
  logic            rst_n;
  rd_req_t         rd_req;
  rd_rsp_t         rd_rsp;
  logic            exu_valid;
  exu_to_wb_t      exu_data;
  logic            exu_ready;
  logic            if_valid;
  logic [xlen-1:0] if_next_pc;
  logic            if_ready;

  logic [xlen-1:0] gpr_model [nreg];
  logic [xlen-1:0] mtvec_m;
  logic [xlen-1:0] mepc_m;
  logic [xlen-1:0] mstatus_m;
  logic [xlen-1:0] mcause_m;
  int              seed = 32'he68d_b05e;
  int              errors = 0;
  int              errors_seen = 0;
  int              tests_run = 0;
  int              tests_passed = 0;

  reg_csr_unit dut_i (.*);

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  initial begin
    #(2 * budget_cycles * clk_period);
    $display("Watchdog expired, the run timed out before the tests finished");
    $display("TEST RESULT: FAIL");
    $finish;
  end

  task automatic compare_word(input string name, input logic [xlen-1:0] exp,
                              input logic [xlen-1:0] act);
    if (act !== exp) begin
      errors++;
      $display("** Error %s: expected %h, got %h", name, exp, act);
    end
  endtask

  task automatic compare_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      errors++;
      $display("** Error %s: expected %h, got %h", name, exp, act);
    end
  endtask

  task automatic compare_rsp(input string name, input rd_rsp_t exp, input rd_rsp_t act);
    compare_word({name, ".src1"}, exp.src1, act.src1);
    compare_word({name, ".src2"}, exp.src2, act.src2);
    compare_word({name, ".csr_data"}, exp.csr_data, act.csr_data);
  endtask

  task automatic end_test(input string name);
    tests_run++;
    if (errors == errors_seen) begin
      tests_passed++;
      $display("%s: ok", name);
    end else begin
      $display("%s: %0d errors", name, errors - errors_seen);
    end
    errors_seen = errors;
  endtask

  function automatic logic [xlen-1:0] rand_pc();
    return $random(seed) & 32'hffff_fffc;
  endfunction

  function automatic exu_to_wb_t make_result(input logic [xlen-1:0] pc, input reg_idx_t rd,
      input logic wen, input logic [xlen-1:0] wdata, input csr_op_e op, input csr_addr_e addr,
      input logic [xlen-1:0] cdata);
    return '{pc: pc, rd: rd, gpr_wen: wen, gpr_wdata: wdata, csr_op: op, csr_addr: addr,
             csr_wdata: cdata};
  endfunction

  // Reference read value built from the CSR read rule
  function automatic logic [xlen-1:0] expected_csr(input csr_addr_e addr, input logic ecall,
                                                   input logic mret);
    if (ecall) return mtvec_m;
    if (mret) return mepc_m;
    case (addr)
      csr_mtvec:     return mtvec_m;
      csr_mepc:      return mepc_m;
      csr_mstatus:   return mstatus_m;
      csr_mcause:    return mcause_m;
      csr_mvendorid: return mvendorid_value;
      csr_marchid:   return marchid_value;
      default:       return '0;
    endcase
  endfunction

  task automatic apply_commit(input exu_to_wb_t d);
    if (d.gpr_wen && d.rd != '0) begin
      gpr_model[d.rd] = d.gpr_wdata;
    end
    case (d.csr_op)
      csr_write: begin
        case (d.csr_addr)
          csr_mtvec:   mtvec_m = d.csr_wdata;
          csr_mepc:    mepc_m = d.csr_wdata;
          csr_mstatus: mstatus_m = d.csr_wdata;
          csr_mcause:  mcause_m = d.csr_wdata;
          default: ;
        endcase
      end
      csr_ecall: begin
        mepc_m = d.pc;
        mcause_m = 32'h0000_000b;
        mstatus_m = 32'h0000_1800;
      end
      csr_mret: begin
        mstatus_m[3] = mstatus_m[7];
        mstatus_m[7] = 1'b1;
        mstatus_m[12:11] = 2'b00;
      end
      default: ;
    endcase
  endtask

  task automatic send_result(input exu_to_wb_t data);
    @(negedge clk);
    exu_valid = 1'b1;
    exu_data = data;
    #settle;
    while (!exu_ready) begin
      @(negedge clk);
      #settle;
    end
    @(posedge clk);
    @(negedge clk);
    exu_valid = 1'b0;
  endtask

  // Holds if_ready low for stall cycles once if_valid is seen, then accepts
  task automatic accept_fetch(input int stall, output logic [xlen-1:0] next_pc);
    logic [xlen-1:0] held_pc;
    @(negedge clk);
    #settle;
    while (!if_valid) begin
      @(negedge clk);
      #settle;
    end
    held_pc = if_next_pc;
    repeat (stall) begin
      @(negedge clk);
      #settle;
      compare_flag("if_valid", 1'b1, if_valid);
      compare_word("if_next_pc", held_pc, if_next_pc);
      compare_flag("exu_ready", 1'b0, exu_ready);
    end
    @(negedge clk);
    if_ready = 1'b1;
    #settle;
    next_pc = if_next_pc;
    @(posedge clk);
    @(negedge clk);
    if_ready = 1'b0;
  endtask

  task automatic check_read(input reg_idx_t rs1, input reg_idx_t rs2, input csr_addr_e addr,
                            input logic ecall, input logic mret);
    rd_rsp_t exp;
    @(negedge clk);
    rd_req = '{rs1: rs1, rs2: rs2, csr_addr: addr, inst_ecall: ecall, inst_mret: mret};
    #settle;
    exp = '{src1: gpr_model[rs1], src2: gpr_model[rs2],
            csr_data: expected_csr(addr, ecall, mret)};
    compare_rsp("rd_rsp", exp, rd_rsp);
  endtask

  task automatic check_all_csrs(input reg_idx_t rs1, input reg_idx_t rs2);
    check_read(rs1, rs2, csr_mstatus, 1'b0, 1'b0);
    check_read(rs1, rs2, csr_mtvec, 1'b0, 1'b0);
    check_read(rs1, rs2, csr_mepc, 1'b0, 1'b0);
    check_read(rs1, rs2, csr_mcause, 1'b0, 1'b0);
    check_read(rs1, rs2, csr_mvendorid, 1'b0, 1'b0);
    check_read(rs1, rs2, csr_marchid, 1'b0, 1'b0);
    check_read(rs1, rs2, csr_unknown, 1'b0, 1'b0);
  endtask

  task automatic run_result(input exu_to_wb_t data, input int stall);
    logic [xlen-1:0] next_pc;
    logic [xlen-1:0] exp_pc;
    case (data.csr_op)
      csr_ecall: exp_pc = mtvec_m;
      csr_mret:  exp_pc = mepc_m;
      default:   exp_pc = data.pc + 32'd4;
    endcase
    send_result(data);
    accept_fetch(stall, next_pc);
    compare_word("if_next_pc", exp_pc, next_pc);
    apply_commit(data);
  endtask

  task automatic run_csr(input csr_op_e op, input csr_addr_e addr, input logic [xlen-1:0] data,
                         input int stall);
    run_result(make_result(rand_pc(), '0, 1'b0, '0, op, addr, data), stall);
  endtask

  task automatic test_reset();
    compare_flag("if_valid", 1'b0, if_valid);
    compare_flag("exu_ready", 1'b1, exu_ready);
    check_all_csrs(4'd0, 4'd0);
    end_test("reset state");
  endtask

  task automatic test_gprs();
    // Index 0 goes through the same path and must stay zero
    for (int i = 0; i < nreg; i++) begin
      run_result(make_result(rand_pc(), reg_idx_t'(i), 1'b1, $random(seed), csr_none,
                             csr_mstatus, '0), 0);
    end
    run_result(make_result(rand_pc(), 4'd5, 1'b0, $random(seed), csr_none, csr_mstatus, '0), 0);
    for (int i = 0; i < nreg; i++) begin
      check_read(reg_idx_t'(i), reg_idx_t'(nreg - 1 - i), csr_mstatus, 1'b0, 1'b0);
    end
    end_test("general registers");
  endtask

  task automatic test_csr_writes();
    run_csr(csr_write, csr_mtvec, rand_pc(), 0);
    run_csr(csr_write, csr_mepc, rand_pc(), 0);
    run_csr(csr_write, csr_mcause, $random(seed), 0);
    run_csr(csr_write, csr_mstatus, $random(seed), 0);
    run_csr(csr_write, csr_mvendorid, $random(seed), 0);
    run_csr(csr_write, csr_marchid, $random(seed), 0);
    run_csr(csr_write, csr_unknown, $random(seed), 0);
    check_all_csrs(4'd1, 4'd2);
    end_test("csr writes");
  endtask

  task automatic test_ecall();
    run_csr(csr_write, csr_mtvec, rand_pc(), 0);
    run_csr(csr_ecall, csr_mstatus, '0, 1);
    check_all_csrs(4'd3, 4'd4);
    check_read(4'd3, 4'd4, csr_mcause, 1'b1, 1'b0);
    end_test("ecall");
  endtask

  task automatic test_mret();
    // MPP set, MPIE set and MIE clear before the mret
    run_csr(csr_write, csr_mstatus, ($random(seed) | 32'h0000_1880) & ~32'h0000_0008, 0);
    run_csr(csr_write, csr_mepc, rand_pc(), 0);
    run_csr(csr_mret, csr_mstatus, '0, 2);
    check_all_csrs(4'd6, 4'd8);
    check_read(4'd6, 4'd8, csr_mtvec, 1'b0, 1'b1);
    end_test("mret");
  endtask

  task automatic test_backpressure();
    exu_to_wb_t      first;
    exu_to_wb_t      second;
    logic [xlen-1:0] pc_a;
    logic [xlen-1:0] pc_b;
    first = make_result(rand_pc(), 4'd7, 1'b1, $random(seed), csr_none, csr_mstatus, '0);
    second = make_result(rand_pc(), 4'd9, 1'b1, $random(seed), csr_write, csr_mcause,
                         $random(seed));
    send_result(first);
    fork
      accept_fetch(3, pc_a);
      begin
        check_read(4'd7, 4'd9, csr_mcause, 1'b0, 1'b0);
        send_result(second);
      end
    join
    compare_word("if_next_pc", first.pc + 32'd4, pc_a);
    apply_commit(first);
    check_read(4'd7, 4'd9, csr_mcause, 1'b0, 1'b0);
    accept_fetch(1, pc_b);
    compare_word("if_next_pc", second.pc + 32'd4, pc_b);
    apply_commit(second);
    check_read(4'd7, 4'd9, csr_mcause, 1'b0, 1'b0);
    end_test("back-pressure");
  endtask

  initial begin
    rst_n = 1'b0;
    rd_req = '0;
    exu_valid = 1'b0;
    exu_data = '0;
    if_ready = 1'b0;
    for (int i = 0; i < nreg; i++) begin
      gpr_model[i] = '0;
    end
    mtvec_m = '0;
    mepc_m = '0;
    mstatus_m = 32'h0000_1800;
    mcause_m = '0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    test_reset();
    test_gprs();
    test_csr_writes();
    test_ecall();
    test_mret();
    test_backpressure();
    $display("Tests passed: %0d of %0d, errors: %0d", tests_passed, tests_run, errors);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* reg_csr_unit.f */
rv_core_pkg.sv
gpr_file.sv
csr_file.sv
wb_stage.sv
reg_csr_unit.sv
tb_reg_csr_unit.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_reg_csr_unit
FILELIST  ?= reg_csr_unit.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "^TEST RESULT: PASS$$"

clean:
	rm -rf $(BUILD_DIR)
